/* build.f */
rtl/remap_pkg.sv
rtl/remap_csr_apb.sv
rtl/chipid_remap_table.sv
rtl/addr_window_offset.sv
rtl/umi_remap_stage.sv
rtl/umi_addr_remap_top.sv
verification/tb_umi_addr_remap.sv

/* Makefile */
SIM      := verilator
TOP      := tb_umi_addr_remap
FILELIST := build.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_umi_addr_remap.sv */
//------------------------------------------------------------
// testbench for the UMI destination remap subsystem
// runs a step table of APB accesses and UMI beats in order
// expected addresses are worked out by hand from the
// priority rule; downstream ready is randomized throughout
// payload of beat n is derived from n, so order is checked
//------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_umi_addr_remap import remap_pkg::*;;

    localparam logic [1:0] k_wr   = 2'd0;
    localparam logic [1:0] k_rd   = 2'd1;
    localparam logic [1:0] k_beat = 2'd2;

    typedef struct packed {
        logic [1:0]        kind;
        logic [apb_aw-1:0] addr;
        logic [apb_dw-1:0] data;      // write data or expected read data
        logic              err;       // expected pslverr
        logic [umi_aw-1:0] dst;       // beat address sent
        logic [umi_aw-1:0] exp_dst;   // address expected out
    } step_t;

    logic              clk             = 1'b0;
    logic              arst_n          = 1'b0;
    logic              psel            = 1'b0;
    logic              penable         = 1'b0;
    logic              pwrite          = 1'b0;
    logic [apb_aw-1:0] paddr           = '0;
    logic [apb_dw-1:0] pwdata          = '0;
    logic [apb_dw-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              umi_in_valid    = 1'b0;
    logic [umi_cw-1:0] umi_in_cmd      = '0;
    logic [umi_aw-1:0] umi_in_dstaddr  = '0;
    logic [umi_aw-1:0] umi_in_srcaddr  = '0;
    logic [umi_dw-1:0] umi_in_data     = '0;
    logic              umi_in_ready;
    logic              umi_out_valid;
    logic [umi_cw-1:0] umi_out_cmd;
    logic [umi_aw-1:0] umi_out_dstaddr;
    logic [umi_aw-1:0] umi_out_srcaddr;
    logic [umi_dw-1:0] umi_out_data;
    logic              umi_out_ready   = 1'b0;

    step_t             steps[$];
    logic [umi_aw-1:0] exp_dst_q[$];      // one entry per accepted input beat
    logic [31:0]       n_in            = '0;
    logic [31:0]       n_out           = '0;
    int                errors          = 0;
    int                checks          = 0;
    int                seed            = 32'h0b96_243c;

    umi_addr_remap_top i_umi_addr_remap_top (.*);

    always #50 clk = ~clk;                // 100 ns period

    // downstream ready about three cycles in four
    always @(posedge clk) begin
        #10;
        umi_out_ready = ($random(seed) & 3) != 0;
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic void add_step(input logic [1:0] kind, input logic [apb_aw-1:0] addr,
                                     input logic [apb_dw-1:0] data, input logic err,
                                     input logic [umi_aw-1:0] dst,
                                     input logic [umi_aw-1:0] exp_dst);
        steps.push_back(step_t'({kind, addr, data, err, dst, exp_dst}));
    endfunction

    // setup phase, then access phase, no wait states
    task automatic apb_transfer(input logic wr, input logic [apb_aw-1:0] addr,
                                input logic [apb_dw-1:0] data, input logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wr ? data : '0;
        @(posedge clk);
        #10 penable = 1'b1;
        @(negedge clk);                   // mid access phase
        check_val("pready", 1'b1, pready);
        check_val("pslverr", err, pslverr);
        if (!wr)
            check_val("prdata", data, prdata);
        @(posedge clk);                   // write lands here
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_beat(input logic [umi_aw-1:0] dst, input logic [umi_aw-1:0] exp_dst);
        umi_in_valid   = 1'b1;
        umi_in_cmd     = 32'hc0de_0000 + n_in;
        umi_in_dstaddr = dst;
        umi_in_srcaddr = {32'h5a5a_0000, n_in};
        umi_in_data    = {n_in, ~n_in};
        @(negedge clk);
        while (!umi_in_ready) @(negedge clk);  // watchdog covers a stuck ready
        exp_dst_q.push_back(exp_dst);
        n_in++;
        @(posedge clk);                   // beat taken here
        #10 umi_in_valid = 1'b0;
    endtask

    // output beats transfer at the next rising edge, checked half a cycle early
    always @(negedge clk) begin
        if (arst_n && umi_out_valid && umi_out_ready) begin
            if (exp_dst_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: output beat that was never sent", $time);
            end else begin
                check_val("umi_out_dstaddr", exp_dst_q.pop_front(), umi_out_dstaddr);
                check_val("umi_out_cmd", 32'hc0de_0000 + n_out, umi_out_cmd);
                check_val("umi_out_srcaddr", {32'h5a5a_0000, n_out}, umi_out_srcaddr);
                check_val("umi_out_data", {n_out, ~n_out}, umi_out_data);
                n_out++;
            end
        end
    end

    initial begin
        // chip 0x21 local, window 0x0000_2000_0000_0000 .. 0x0000_2200_0000_ffff
        add_step(k_wr, reg_chipid,          32'h0000_0021, 1'b0, '0, '0);
        add_step(k_rd, reg_chipid,          32'h0000_0021, 1'b0, '0, '0);
        add_step(k_wr, reg_map_base,        32'h0b22_0022, 1'b0, '0, '0); // 0x22 to 0xb22
        add_step(k_wr, reg_map_base + 8'h4, 32'h0c22_0022, 1'b0, '0, '0); // same old id
        add_step(k_wr, reg_map_base + 8'h8, 32'h0d33_0033, 1'b0, '0, '0); // kept disabled
        add_step(k_wr, reg_map_base + 8'hc, 32'h0e21_0021, 1'b0, '0, '0); // hits local id
        add_step(k_rd, reg_map_base + 8'h4, 32'h0c22_0022, 1'b0, '0, '0);
        add_step(k_wr, reg_win_lo_h,        32'h0000_2000, 1'b0, '0, '0);
        add_step(k_wr, reg_win_hi_l,        32'h0000_ffff, 1'b0, '0, '0);
        add_step(k_wr, reg_win_hi_h,        32'h0000_2200, 1'b0, '0, '0);
        add_step(k_wr, reg_ofs_l,           32'h1000_0000, 1'b0, '0, '0);
        add_step(k_rd, reg_win_hi_h,        32'h0000_2200, 1'b0, '0, '0);
        add_step(k_rd, reg_ofs_l,           32'h1000_0000, 1'b0, '0, '0);
        add_step(k_wr, 8'h40,               32'hffff_ffff, 1'b1, '0, '0); // unmapped
        add_step(k_rd, 8'h40,               32'h0000_0000, 1'b1, '0, '0);
        add_step(k_rd, reg_map_base,        32'h0b22_0022, 1'b0, '0, '0); // no aliasing
        add_step(k_wr, reg_ctrl,            32'h0000_000b, 1'b0, '0, '0); // entries 0 1 3
        add_step(k_rd, reg_ctrl,            32'h0000_000b, 1'b0, '0, '0);
        // window off; remap hit, disabled entry, no match, local id
        add_step(k_beat, '0, '0, 1'b0, 64'ha500_2212_3456_7890, 64'ha50b_2212_3456_7890);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_3300_0000_0080, 64'h0000_3300_0000_0080);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_4400_0000_00c0, 64'h0000_4400_0000_00c0);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2100_0000_0100, 64'h0000_2100_0000_0100);
        add_step(k_wr, reg_ctrl,            32'h0000_010b, 1'b0, '0, '0); // window on
        // local in window, low bound, high bound over entry 0, past high, below low
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2100_0000_0100, 64'h0000_2100_0000_0100);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2000_0000_0000, 64'h0000_2000_1000_0000);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2200_0000_ffff, 64'h0000_2200_1000_ffff);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2200_0001_0000, 64'h000b_2200_0001_0000);
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_1fff_ffff_ffff, 64'h0000_1fff_ffff_ffff);
        add_step(k_wr, reg_ctrl,            32'h0000_0000, 1'b0, '0, '0); // all off
        add_step(k_beat, '0, '0, 1'b0, 64'h0000_2200_0000_0040, 64'h0000_2200_0000_0040);

        repeat (2) @(posedge clk);
        #10 arst_n = 1'b1;
        check_val("umi_out_valid", 1'b0, umi_out_valid);
        check_val("pslverr", 1'b0, pslverr);
        for (int a = 0; a < 64; a += 4) begin
            apb_transfer(1'b0, apb_aw'(a), '0, 1'b0);  // every register reads zero
        end

        foreach (steps[i]) begin
            case (steps[i].kind)
                k_wr:    apb_transfer(1'b1, steps[i].addr, steps[i].data, steps[i].err);
                k_rd:    apb_transfer(1'b0, steps[i].addr, steps[i].data, steps[i].err);
                default: send_beat(steps[i].dst, steps[i].exp_dst);
            endcase
        end

        while (exp_dst_q.size() != 0) @(posedge clk);  // drain the stage
        repeat (2) @(posedge clk);
        check_val("beats out", n_in, n_out);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // run limit scales with the step table
    initial begin
        int limit;
        #1;
        limit = steps.size() * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/umi_addr_remap_top.sv */
//----------------------------------------------------------
// UMI destination address remap subsystem
// APB config block, chip-ID remap table, address window
// and a one-cycle registered stage on the UMI path
// cmd, srcaddr and data pass through unchanged
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module umi_addr_remap_top import remap_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    // APB
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [apb_dw-1:0] pwdata,
    output logic [apb_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    // UMI in
    input  logic              umi_in_valid,
    input  logic [umi_cw-1:0] umi_in_cmd,
    input  logic [umi_aw-1:0] umi_in_dstaddr,
    input  logic [umi_aw-1:0] umi_in_srcaddr,
    input  logic [umi_dw-1:0] umi_in_data,
    output logic              umi_in_ready,
    // UMI out
    output logic              umi_out_valid,
    output logic [umi_cw-1:0] umi_out_cmd,
    output logic [umi_aw-1:0] umi_out_dstaddr,
    output logic [umi_aw-1:0] umi_out_srcaddr,
    output logic [umi_dw-1:0] umi_out_data,
    input  logic              umi_out_ready
);

    logic [id_w-1:0]        chipid;
    logic [n_maps-1:0]      map_enable;
    logic [id_w*n_maps-1:0] map_old_ids;
    logic [id_w*n_maps-1:0] map_new_ids;
    logic                   win_enable;
    logic [umi_aw-1:0]      win_low;
    logic [umi_aw-1:0]      win_high;
    logic [umi_aw-1:0]      win_offset;
    logic                   map_hit;
    logic [umi_aw-1:0]      map_addr;
    logic                   win_hit;
    logic [umi_aw-1:0]      win_addr;

    remap_csr_apb i_remap_csr_apb (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .chipid      (chipid),
        .map_enable  (map_enable),
        .map_old_ids (map_old_ids),
        .map_new_ids (map_new_ids),
        .win_enable  (win_enable),
        .win_low     (win_low),
        .win_high    (win_high),
        .win_offset  (win_offset)
    );

    chipid_remap_table i_chipid_remap_table (
        .dstaddr     (umi_in_dstaddr),
        .map_enable  (map_enable),
        .map_old_ids (map_old_ids),
        .map_new_ids (map_new_ids),
        .map_hit     (map_hit),
        .map_addr    (map_addr)
    );

    addr_window_offset i_addr_window_offset (
        .dstaddr    (umi_in_dstaddr),
        .win_enable (win_enable),
        .win_low    (win_low),
        .win_high   (win_high),
        .win_offset (win_offset),
        .win_hit    (win_hit),
        .win_addr   (win_addr)
    );

    umi_remap_stage i_umi_remap_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .chipid          (chipid),
        .map_hit         (map_hit),
        .map_addr        (map_addr),
        .win_hit         (win_hit),
        .win_addr        (win_addr),
        .umi_in_valid    (umi_in_valid),
        .umi_in_cmd      (umi_in_cmd),
        .umi_in_dstaddr  (umi_in_dstaddr),
        .umi_in_srcaddr  (umi_in_srcaddr),
        .umi_in_data     (umi_in_data),
        .umi_out_ready   (umi_out_ready),
        .umi_in_ready    (umi_in_ready),
        .umi_out_valid   (umi_out_valid),
        .umi_out_cmd     (umi_out_cmd),
        .umi_out_dstaddr (umi_out_dstaddr),
        .umi_out_srcaddr (umi_out_srcaddr),
        .umi_out_data    (umi_out_data)
    );

endmodule

`default_nettype wire

/* rtl/umi_remap_stage.sv */
//----------------------------------------------------------
// one-slot registered valid/ready stage
// address priority: local chip ID, window, remap, as is
// config is sampled in the cycle the beat is accepted
// full rate when the downstream keeps ready high
// output is held until accepted, input stalls meanwhile
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module umi_remap_stage import remap_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [id_w-1:0]   chipid,
    input  logic              map_hit,
    input  logic [umi_aw-1:0] map_addr,
    input  logic              win_hit,
    input  logic [umi_aw-1:0] win_addr,
    input  logic              umi_in_valid,
    input  logic [umi_cw-1:0] umi_in_cmd,
    input  logic [umi_aw-1:0] umi_in_dstaddr,
    input  logic [umi_aw-1:0] umi_in_srcaddr,
    input  logic [umi_dw-1:0] umi_in_data,
    input  logic              umi_out_ready,
    output logic              umi_in_ready,
    output logic              umi_out_valid,
    output logic [umi_cw-1:0] umi_out_cmd,
    output logic [umi_aw-1:0] umi_out_dstaddr,
    output logic [umi_aw-1:0] umi_out_srcaddr,
    output logic [umi_dw-1:0] umi_out_data
);

    logic              dst_local;   // beat targets this chip
    logic [umi_aw-1:0] dst_next;
    logic              in_accept;
    logic              valid_q;

    assign dst_local = (umi_in_dstaddr[id_sb +: id_w] == chipid);

    always_comb begin
        if (dst_local) begin
            dst_next = umi_in_dstaddr;
        end else if (win_hit) begin
            dst_next = win_addr;
        end else if (map_hit) begin
            dst_next = map_addr;
        end else begin
            dst_next = umi_in_dstaddr;
        end
    end

    assign umi_in_ready = !valid_q || umi_out_ready;  // empty or draining
    assign in_accept    = umi_in_valid && umi_in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (umi_in_ready) begin
            valid_q <= umi_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_accept) begin
            umi_out_cmd     <= umi_in_cmd;
            umi_out_dstaddr <= dst_next;
            umi_out_srcaddr <= umi_in_srcaddr;
            umi_out_data    <= umi_in_data;
        end
    end

    assign umi_out_valid = valid_q;

    // stalled beat keeps valid and payload until taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        umi_out_valid && !umi_out_ready |=> umi_out_valid
            && $stable({umi_out_cmd, umi_out_dstaddr, umi_out_srcaddr, umi_out_data}));

endmodule

`default_nettype wire

/* rtl/addr_window_offset.sv */
//----------------------------------------------------------
// address window check and offset add, combinational
// both bounds are inclusive and compared unsigned
// the offset wraps modulo 2**64
// a window with low above high never hits
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module addr_window_offset import remap_pkg::*; (
    input  logic [umi_aw-1:0] dstaddr,
    input  logic              win_enable,
    input  logic [umi_aw-1:0] win_low,
    input  logic [umi_aw-1:0] win_high,
    input  logic [umi_aw-1:0] win_offset,
    output logic              win_hit,
    output logic [umi_aw-1:0] win_addr
);

    logic above_low;   // dstaddr >= low
    logic below_high;  // dstaddr <= high

    assign above_low  = (dstaddr >= win_low);
    assign below_high = (dstaddr <= win_high);

    assign win_hit  = win_enable && above_low && below_high;
    assign win_addr = dstaddr + win_offset;   // carry out of bit 63 dropped

endmodule

`default_nettype wire

/* rtl/chipid_remap_table.sv */
//----------------------------------------------------------
// chip-ID remap lookup, purely combinational
// eight entries, each with its own enable
// lowest-indexed enabled match supplies the new ID
// only the chip-ID field of the address is rewritten
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module chipid_remap_table import remap_pkg::*; (
    input  logic [umi_aw-1:0]        dstaddr,
    input  logic [n_maps-1:0]        map_enable,
    input  logic [id_w*n_maps-1:0]   map_old_ids,
    input  logic [id_w*n_maps-1:0]   map_new_ids,
    output logic                     map_hit,
    output logic [umi_aw-1:0]        map_addr
);

    logic [id_w-1:0]   addr_id;   // chip-ID field of the incoming address
    logic [n_maps-1:0] id_match;  // per entry hit
    logic [id_w-1:0]   new_id;

    assign addr_id = dstaddr[id_sb +: id_w];

    always_comb begin
        id_match = '0;
        new_id   = addr_id;   // no hit keeps the field
        // walk down so the lowest index is applied last and wins
        for (int k = n_maps - 1; k >= 0; k--) begin
            id_match[k] = map_enable[k] && (map_old_ids[k*id_w +: id_w] == addr_id);
            if (id_match[k]) begin
                new_id = map_new_ids[k*id_w +: id_w];
            end
        end
        map_hit = |id_match;

        if (map_enable == '0) begin
            a_no_hit_disabled: assert (!map_hit)
                else $error("remap hit with every entry disabled");
        end
    end

    // splice the new ID into the address, other bits untouched
    always_comb begin
        map_addr                  = dstaddr;
        map_addr[id_sb +: id_w]   = new_id;
    end

endmodule

`default_nettype wire

/* rtl/remap_csr_apb.sv */
//----------------------------------------------------------
// APB slave with the remap and window configuration
// no wait states, pready is always high
// writes land at the edge that ends the access phase
// misaligned or unmapped offsets give pslverr, a write
// there is dropped and a read returns zero
//----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module remap_csr_apb import remap_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [apb_aw-1:0]        paddr,
    input  logic [apb_dw-1:0]        pwdata,
    output logic [apb_dw-1:0]        prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic [id_w-1:0]          chipid,
    output logic [n_maps-1:0]        map_enable,
    output logic [id_w*n_maps-1:0]   map_old_ids,
    output logic [id_w*n_maps-1:0]   map_new_ids,
    output logic                     win_enable,
    output logic [umi_aw-1:0]        win_low,
    output logic [umi_aw-1:0]        win_high,
    output logic [umi_aw-1:0]        win_offset
);

    logic [ctrl_win_bit:0] ctrl_q;          // entry enables + window enable
    logic [id_w-1:0]       chipid_q;
    logic [umi_aw-1:0]     win_lo_q;
    logic [umi_aw-1:0]     win_hi_q;
    logic [umi_aw-1:0]     ofs_q;
    logic [apb_dw-1:0]     map_q [n_maps];  // {new id, old id}
    logic                  fixed_sel;       // one of the 0x00..0x1C regs
    logic                  map_sel;         // inside the entry block
    logic [map_iw-1:0]     map_idx;
    logic                  addr_err;
    logic                  access;          // access phase of any transfer
    logic                  wr_en;
    logic [apb_dw-1:0]     rd_data;

    assign fixed_sel = paddr inside {reg_ctrl, reg_chipid, reg_win_lo_l, reg_win_lo_h,
                                     reg_win_hi_l, reg_win_hi_h, reg_ofs_l, reg_ofs_h};
    assign map_sel   = (paddr >= reg_map_base) && (paddr < reg_map_base + 4 * n_maps);
    assign map_idx   = map_iw'((paddr - reg_map_base) >> 2);
    assign addr_err  = (paddr[1:0] != 2'b00) || !(fixed_sel || map_sel);

    assign access = psel && penable;
    assign wr_en  = access && pwrite && !addr_err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= reg_rst[ctrl_win_bit:0];
            chipid_q <= reg_rst[id_w-1:0];
            win_lo_q <= {reg_rst, reg_rst};
            win_hi_q <= {reg_rst, reg_rst};
            ofs_q    <= {reg_rst, reg_rst};
            for (int k = 0; k < n_maps; k++) begin
                map_q[k] <= reg_rst;
            end
        end else if (wr_en) begin
            case (paddr)
                reg_ctrl:     ctrl_q                <= pwdata[ctrl_win_bit:0];
                reg_chipid:   chipid_q              <= pwdata[id_w-1:0];
                reg_win_lo_l: win_lo_q[31:0]        <= pwdata;
                reg_win_lo_h: win_lo_q[63:32]       <= pwdata;
                reg_win_hi_l: win_hi_q[31:0]        <= pwdata;
                reg_win_hi_h: win_hi_q[63:32]       <= pwdata;
                reg_ofs_l:    ofs_q[31:0]           <= pwdata;
                reg_ofs_h:    ofs_q[63:32]          <= pwdata;
                default:      map_q[map_idx]        <= pwdata; // only map_sel gets here
            endcase
        end
    end

    // read mux, unused upper bits read as zero
    always_comb begin
        case (paddr)
            reg_ctrl:     rd_data = {{(apb_dw-ctrl_win_bit-1){1'b0}}, ctrl_q};
            reg_chipid:   rd_data = {{(apb_dw-id_w){1'b0}}, chipid_q};
            reg_win_lo_l: rd_data = win_lo_q[31:0];
            reg_win_lo_h: rd_data = win_lo_q[63:32];
            reg_win_hi_l: rd_data = win_hi_q[31:0];
            reg_win_hi_h: rd_data = win_hi_q[63:32];
            reg_ofs_l:    rd_data = ofs_q[31:0];
            reg_ofs_h:    rd_data = ofs_q[63:32];
            default:      rd_data = map_sel ? map_q[map_idx] : '0;
        endcase
    end

    assign prdata  = (access && !addr_err) ? rd_data : '0;
    assign pready  = 1'b1;                  // zero wait states
    assign pslverr = access && addr_err;

    // configuration fan-out
    assign chipid     = chipid_q;
    assign map_enable = ctrl_q[n_maps-1:0];
    assign win_enable = ctrl_q[ctrl_win_bit];
    assign win_low    = win_lo_q;
    assign win_high   = win_hi_q;
    assign win_offset = ofs_q;

    for (genvar g = 0; g < n_maps; g++) begin : g_map_out
        assign map_old_ids[g*id_w +: id_w] = map_q[g][id_w-1:0];
        assign map_new_ids[g*id_w +: id_w] = map_q[g][2*id_w-1:id_w];
    end

    // an error is only flagged in an access phase that follows a setup phase
    a_pslverr_access: assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> psel && penable && $past(psel) && !$past(penable));

endmodule

`default_nettype wire

/* rtl/remap_pkg.sv */
//----------------------------------------------------------
// shared widths, address fields and CSR map for the UMI
// destination remap subsystem
// chip-ID field sits at bits id_sb+id_w-1 .. id_sb
// register map is word aligned, APB data is 32 bits
//----------------------------------------------------------

`default_nettype none

package remap_pkg;

    // UMI bus widths
    localparam int umi_aw = 64;             // address width
    localparam int umi_cw = 32;             // command width
    localparam int umi_dw = 64;             // data width

    // chip-ID field inside the address
    localparam int id_w  = 16;              // chip-ID width
    localparam int id_sb = 40;              // first bit, field is 55..40

    // remap table size
    localparam int n_maps = 8;
    localparam int map_iw = $clog2(n_maps); // entry index width

    // APB side
    localparam int apb_aw = 8;
    localparam int apb_dw = 32;

    // control register layout, entry enables in the low bits
    localparam int ctrl_win_bit = 8;        // window enable

    // register offsets
    localparam logic [apb_aw-1:0] reg_ctrl     = 8'h00;
    localparam logic [apb_aw-1:0] reg_chipid   = 8'h04;
    localparam logic [apb_aw-1:0] reg_win_lo_l = 8'h08;
    localparam logic [apb_aw-1:0] reg_win_lo_h = 8'h0C;
    localparam logic [apb_aw-1:0] reg_win_hi_l = 8'h10;
    localparam logic [apb_aw-1:0] reg_win_hi_h = 8'h14;
    localparam logic [apb_aw-1:0] reg_ofs_l    = 8'h18;
    localparam logic [apb_aw-1:0] reg_ofs_h    = 8'h1C;
    localparam logic [apb_aw-1:0] reg_map_base = 8'h20; // entry k at base + 4*k

    // reset value shared by every configuration register
    localparam logic [apb_dw-1:0] reg_rst = '0;

endpackage

`default_nettype wire
